//--- e0c_pkg.sv
`default_nettype none

package e0c_pkg;

    typedef logic [3:0]  nib_t;
    typedef logic [11:0] addr_t;
    typedef logic [11:0] instr_t;
    typedef logic [1:0]  rcode_t;   // 0 A, 1 B, 2 M(X), 3 M(Y)

    // Decoded operations of the load group
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LD_X_E,
        OP_LD_Y_E,
        OP_LBPX,
        OP_LD_R_I,
        OP_LDPX_I,
        OP_LDPY_I,
        OP_LD_PART_R,
        OP_LD_R_PART,
        OP_LD_R_Q,
        OP_LDPX_R_Q,
        OP_LDPY_R_Q
    } op_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_READ,
        ST_EXEC,
        ST_WRITE,
        ST_WRITE_HI
    } cpu_state_t;

    typedef enum logic [2:0] {
        PART_XP,
        PART_XH,
        PART_XL,
        PART_YP,
        PART_YH,
        PART_YL
    } part_t;

endpackage

`default_nettype wire

//--- instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decode import e0c_pkg::*; (
    input  instr_t     instr,
    output op_t        op,
    output rcode_t     rq_dst,
    output rcode_t     rq_src,
    output part_t      part,
    output nib_t       imm4,
    output logic [7:0] imm8
);

    part_t part_sel;

    // Bit 4 picks X or Y, bits 3:2 pick P, H or L
    always_comb begin
        case ({instr[4], instr[3:2]})
            3'b000:  part_sel = PART_XP;
            3'b001:  part_sel = PART_XH;
            3'b010:  part_sel = PART_XL;
            3'b100:  part_sel = PART_YP;
            3'b101:  part_sel = PART_YH;
            3'b110:  part_sel = PART_YL;
            default: part_sel = PART_XP;
        endcase
    end

    always_comb begin
        op     = OP_NOP;
        rq_dst = 2'd0;
        rq_src = 2'd0;
        part   = PART_XP;
        imm4   = instr[3:0];
        imm8   = instr[7:0];
        case (instr[11:8])
            4'hB: op = OP_LD_X_E;
            4'h8: op = OP_LD_Y_E;
            4'h9: begin
                op     = OP_LBPX;
                rq_dst = 2'd2;                  // Always M(X)
            end
            4'hE: begin
                case (instr[7:4])
                    4'h0, 4'h1, 4'h2, 4'h3: begin
                        op     = OP_LD_R_I;
                        rq_dst = instr[5:4];
                    end
                    4'h6: begin
                        op     = OP_LDPX_I;
                        rq_dst = 2'd2;
                    end
                    4'h7: begin
                        op     = OP_LDPY_I;
                        rq_dst = 2'd3;
                    end
                    4'h8, 4'h9: begin
                        if (instr[3:2] != 2'b11) begin
                            op     = OP_LD_PART_R;
                            rq_src = instr[1:0];
                            part   = part_sel;
                        end
                    end
                    4'hA, 4'hB: begin
                        if (instr[3:2] != 2'b11) begin
                            op     = OP_LD_R_PART;
                            rq_dst = instr[1:0];
                            part   = part_sel;
                        end
                    end
                    4'hC: begin
                        op     = OP_LD_R_Q;
                        rq_dst = instr[3:2];
                        rq_src = instr[1:0];
                    end
                    4'hE: begin
                        op     = OP_LDPX_R_Q;
                        rq_dst = instr[3:2];
                        rq_src = instr[1:0];
                    end
                    4'hF: begin
                        op     = OP_LDPY_R_Q;
                        rq_dst = instr[3:2];
                        rq_src = instr[1:0];
                    end
                    default: op = OP_NOP;
                endcase
            end
            default: op = OP_NOP;
        endcase
    end

endmodule

`default_nettype wire

//--- core_regs.sv
`timescale 1ns/10ps
`default_nettype none

module core_regs import e0c_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  op_t        op,
    input  rcode_t     rq_dst,
    input  rcode_t     rq_src,
    input  part_t      part,
    input  nib_t       wdat,
    input  logic [7:0] imm8,
    input  logic       reg_load,
    input  logic       x_load8,
    input  logic       y_load8,
    input  logic       x_inc,
    input  logic       y_inc,
    output addr_t      x,
    output addr_t      y,
    output nib_t       rd_val
);

    nib_t a;
    nib_t b;
    nib_t part_nib;

    always_comb begin
        case (part)
            PART_XP: part_nib = x[11:8];
            PART_XH: part_nib = x[7:4];
            PART_XL: part_nib = x[3:0];
            PART_YP: part_nib = y[11:8];
            PART_YH: part_nib = y[7:4];
            PART_YL: part_nib = y[3:0];
            default: part_nib = 4'h0;
        endcase
    end

    always_comb begin
        if (op == OP_LD_R_PART) begin
            rd_val = part_nib;
        end else begin
            case (rq_src)
                2'd0:    rd_val = a;
                2'd1:    rd_val = b;
                default: rd_val = 4'h0;     // Memory operands come from the bus
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a <= 4'h0;
            b <= 4'h0;
            x <= 12'h000;
            y <= 12'h000;
        end else begin
            if (reg_load) begin
                if (op == OP_LD_PART_R) begin
                    case (part)
                        PART_XP: x[11:8] <= wdat;
                        PART_XH: x[7:4]  <= wdat;
                        PART_XL: x[3:0]  <= wdat;
                        PART_YP: y[11:8] <= wdat;
                        PART_YH: y[7:4]  <= wdat;
                        PART_YL: y[3:0]  <= wdat;
                        default: ;
                    endcase
                end else if (rq_dst == 2'd0) begin
                    a <= wdat;
                end else if (rq_dst == 2'd1) begin
                    b <= wdat;
                end
            end
            if (x_load8) x[7:0] <= imm8;    // Page nibble kept
            if (y_load8) y[7:0] <= imm8;
            if (x_inc) x <= x + 12'd1;
            if (y_inc) y <= y + 12'd1;
        end
    end

endmodule

`default_nettype wire

//--- wb_data_port.sv
`timescale 1ns/10ps
`default_nettype none

module wb_data_port import e0c_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  req,
    input  logic  req_we,
    input  addr_t req_adr,
    input  nib_t  req_dat,
    output logic  done,
    output nib_t  rdat,
    output logic  wb_cyc,
    output logic  wb_stb,
    output logic  wb_we,
    output addr_t wb_adr,
    output nib_t  wb_dat_w,
    input  nib_t  wb_dat_r,
    input  logic  wb_ack
);

    logic start;

    // No restart while the release cycle is still signalled
    assign start  = req && !wb_cyc && !done;
    assign wb_stb = wb_cyc;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_cyc <= 1'b0;
            wb_we  <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= wb_cyc && wb_ack;
            if (start) begin
                wb_cyc <= 1'b1;
                wb_we  <= req_we;
            end else if (wb_cyc && wb_ack) begin
                wb_cyc <= 1'b0;
                wb_we  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= req_adr;
            wb_dat_w <= req_dat;
        end
        if (wb_cyc && wb_ack && !wb_we) rdat <= wb_dat_r;  // Held until next read
    end

endmodule

`default_nettype wire

//--- exec_control.sv
`timescale 1ns/10ps
`default_nettype none

module exec_control import e0c_pkg::*; #(
    parameter addr_t RESET_PC = 12'h100
) (
    input  logic       clk,
    input  logic       rst,
    input  instr_t     rom_data,
    output addr_t      rom_addr,
    input  op_t        op,
    input  rcode_t     rq_dst,
    input  rcode_t     rq_src,
    input  nib_t       imm4,
    input  logic [7:0] imm8,
    input  addr_t      x,
    input  addr_t      y,
    input  nib_t       rd_val,
    input  nib_t       rdat,
    input  logic       done,
    output instr_t     instr,
    output nib_t       wdat,
    output logic       reg_load,
    output logic       x_load8,
    output logic       y_load8,
    output logic       x_inc,
    output logic       y_inc,
    output logic       req,
    output logic       req_we,
    output addr_t      req_adr,
    output nib_t       req_dat
);

    cpu_state_t state;
    addr_t      pc;
    instr_t     ir;
    nib_t       st_val;
    logic       dst_op;
    logic       src_op;
    logic       need_read;
    logic       need_write;
    logic       in_exec;

    assign rom_addr = pc;
    assign instr    = ir;
    assign in_exec  = (state == ST_EXEC);

    // Ops whose rq_dst / rq_src name an operand
    assign dst_op = (op == OP_LD_R_I) || (op == OP_LD_R_PART) || (op == OP_LD_R_Q) ||
                    (op == OP_LDPX_R_Q) || (op == OP_LDPY_R_Q) || (op == OP_LDPX_I) ||
                    (op == OP_LDPY_I) || (op == OP_LBPX);
    assign src_op = (op == OP_LD_PART_R) || (op == OP_LD_R_Q) ||
                    (op == OP_LDPX_R_Q) || (op == OP_LDPY_R_Q);

    assign need_read  = src_op && rq_src[1];
    assign need_write = dst_op && rq_dst[1];

    always_comb begin
        case (op)
            OP_LD_R_I, OP_LDPX_I, OP_LDPY_I: st_val = imm4;
            OP_LBPX: st_val = (state == ST_WRITE_HI) ? imm8[7:4] : imm8[3:0];
            default: st_val = rq_src[1] ? rdat : rd_val;
        endcase
    end

    assign wdat    = st_val;
    assign req_dat = st_val;

    assign req     = (state == ST_READ) || (state == ST_WRITE) || (state == ST_WRITE_HI);
    assign req_we  = (state != ST_READ);
    assign req_adr = (state == ST_READ) ? (rq_src[0] ? y : x) : (rq_dst[0] ? y : x);

    assign reg_load = in_exec && ((dst_op && !rq_dst[1]) || (op == OP_LD_PART_R));
    assign x_load8  = in_exec && (op == OP_LD_X_E);
    assign y_load8  = in_exec && (op == OP_LD_Y_E);
    // LBPX steps X once between its two writes and once more in EXEC
    assign x_inc = (in_exec && ((op == OP_LDPX_I) || (op == OP_LDPX_R_Q) || (op == OP_LBPX)))
                || ((state == ST_WRITE) && done && (op == OP_LBPX));
    assign y_inc = in_exec && ((op == OP_LDPY_I) || (op == OP_LDPY_R_Q));

    always_ff @(posedge clk) begin
        if (state == ST_FETCH) ir <= rom_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_FETCH;
            pc    <= RESET_PC;
        end else begin
            case (state)
                ST_FETCH: state <= ST_DECODE;
                ST_DECODE: begin
                    if (need_read)       state <= ST_READ;
                    else if (need_write) state <= ST_WRITE;
                    else                 state <= ST_EXEC;
                end
                ST_READ: begin
                    if (done) state <= need_write ? ST_WRITE : ST_EXEC;
                end
                ST_WRITE: begin
                    if (done) state <= (op == OP_LBPX) ? ST_WRITE_HI : ST_EXEC;
                end
                ST_WRITE_HI: begin
                    if (done) state <= ST_EXEC;
                end
                ST_EXEC: begin
                    pc    <= pc + 12'd1;        // No jumps, wraps at 12 bits
                    state <= ST_FETCH;
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core import e0c_pkg::*; #(
    parameter addr_t RESET_PC = 12'h100
) (
    input  logic   clk,
    input  logic   rst,
    output addr_t  rom_addr,
    input  instr_t rom_data,
    output logic   wb_cyc,
    output logic   wb_stb,
    output logic   wb_we,
    output addr_t  wb_adr,
    output nib_t   wb_dat_w,
    input  nib_t   wb_dat_r,
    input  logic   wb_ack
);

    instr_t     instr;
    op_t        op;
    rcode_t     rq_dst;
    rcode_t     rq_src;
    part_t      part;
    nib_t       imm4;
    logic [7:0] imm8;
    addr_t      x;
    addr_t      y;
    nib_t       rd_val;
    nib_t       wdat;
    nib_t       rdat;
    logic       reg_load;
    logic       x_load8;
    logic       y_load8;
    logic       x_inc;
    logic       y_inc;
    logic       req;
    logic       req_we;
    addr_t      req_adr;
    nib_t       req_dat;
    logic       done;

    instr_decode decode (
        .instr  (instr),
        .op     (op),
        .rq_dst (rq_dst),
        .rq_src (rq_src),
        .part   (part),
        .imm4   (imm4),
        .imm8   (imm8)
    );

    core_regs regs (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .rq_dst   (rq_dst),
        .rq_src   (rq_src),
        .part     (part),
        .wdat     (wdat),
        .imm8     (imm8),
        .reg_load (reg_load),
        .x_load8  (x_load8),
        .y_load8  (y_load8),
        .x_inc    (x_inc),
        .y_inc    (y_inc),
        .x        (x),
        .y        (y),
        .rd_val   (rd_val)
    );

    exec_control #(
        .RESET_PC (RESET_PC)
    ) ctrl (
        .clk      (clk),
        .rst      (rst),
        .rom_data (rom_data),
        .rom_addr (rom_addr),
        .op       (op),
        .rq_dst   (rq_dst),
        .rq_src   (rq_src),
        .imm4     (imm4),
        .imm8     (imm8),
        .x        (x),
        .y        (y),
        .rd_val   (rd_val),
        .rdat     (rdat),
        .done     (done),
        .instr    (instr),
        .wdat     (wdat),
        .reg_load (reg_load),
        .x_load8  (x_load8),
        .y_load8  (y_load8),
        .x_inc    (x_inc),
        .y_inc    (y_inc),
        .req      (req),
        .req_we   (req_we),
        .req_adr  (req_adr),
        .req_dat  (req_dat)
    );

    wb_data_port bus (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_we   (req_we),
        .req_adr  (req_adr),
        .req_dat  (req_dat),
        .done     (done),
        .rdat     (rdat),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

`default_nettype wire

//--- cpu_properties.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_properties import e0c_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  wb_cyc,
    input logic  wb_stb,
    input logic  wb_we,
    input addr_t wb_adr,
    input nib_t  wb_dat_w,
    input logic  wb_ack
);

    assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // Request held until the slave acknowledges
    assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_we) && $stable(wb_adr) && $stable(wb_dat_w))
        else $error("bus request changed before wb_ack");

    assert property (@(posedge clk) rst |=> !wb_cyc)
        else $error("wb_cyc high in the cycle after reset");

    assert property (@(posedge clk) rst |-> !(wb_cyc && wb_we))
        else $error("bus write while rst is high");

endmodule

bind cpu_core cpu_properties props (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack)
);

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu
    import e0c_pkg::*;
();

    localparam addr_t START_PC = 12'hFF8;      // Programs run across the 12-bit wrap

    logic   clk;
    logic   rst;
    addr_t  rom_addr;
    instr_t rom_data;
    logic   wb_cyc;
    logic   wb_stb;
    logic   wb_we;
    addr_t  wb_adr;
    nib_t   wb_dat_w;
    nib_t   wb_dat_r = 4'h0;
    logic   wb_ack = 1'b0;

    instr_t rom_mem [4096];
    nib_t   ram_mem [4096];
    nib_t   exp_mem [4096];
    instr_t prog [$];
    addr_t  wr_adr [$];
    nib_t   wr_dat [$];
    addr_t  exp_adr [$];
    nib_t   exp_dat [$];
    int     wait_left = 0;
    logic   busy = 1'b0;
    int     bus_cycles = 0;
    nib_t   m_a;
    nib_t   m_b;
    addr_t  m_x;
    addr_t  m_y;

    assign rom_data = rom_mem[rom_addr];

    cpu_core #(
        .RESET_PC (START_PC)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic nib_t ram_fill(addr_t a);
        return a[11:8] ^ a[7:4] ^ a[3:0] ^ 4'h9;
    endfunction

    // Wishbone RAM with 0 to 3 wait states per transfer
    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4096; i++) ram_mem[i] = ram_fill(addr_t'(i));
            wr_adr.delete();
            wr_dat.delete();
            bus_cycles = 0;
            busy = 1'b0;
            wb_ack = 1'b0;
        end else begin
            if (wb_cyc) bus_cycles++;
            if (wb_ack) begin
                wb_ack = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!busy) begin
                    busy = 1'b1;
                    wait_left = $urandom % 4;
                end
                if (wait_left == 0) begin
                    busy = 1'b0;
                    wb_ack = 1'b1;
                    if (wb_we) begin
                        ram_mem[wb_adr] = wb_dat_w;
                        wr_adr.push_back(wb_adr);
                        wr_dat.push_back(wb_dat_w);
                    end else begin
                        wb_dat_r = ram_mem[wb_adr];
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t got);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %s expected 0x%03h got 0x%03h", name, exp, got));
    endtask

    task automatic check_nib(string name, nib_t exp, nib_t got);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %s expected 0x%01h got 0x%01h", name, exp, got));
    endtask

    task automatic wait_for_pc(addr_t target, int limit, output int cycles);
        cycles = 0;
        while (rom_addr !== target) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit)
                abort_run($sformatf("timeout waiting for rom_addr to reach 0x%03h", target));
        end
    endtask

    task automatic expect_write(addr_t adr, nib_t dat);
        exp_mem[adr] = dat;
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
    endtask

    // Loads prog at START_PC over a NOP fill, then runs the reset sequence
    task automatic start_program();
        addr_t a;
        rst = 1'b1;
        for (int i = 0; i < 4096; i++) begin
            a = addr_t'(i);
            rom_mem[a] = {4'h0, a[11:4] ^ a[7:0]};
        end
        for (int i = 0; i < prog.size(); i++) rom_mem[START_PC + addr_t'(i)] = prog[i];
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_addr("rom_addr", START_PC, rom_addr);
    endtask

    task automatic run_and_check(string name);
        int cycles;
        start_program();
        wait_for_pc(START_PC + addr_t'(prog.size()), 30 * prog.size() + 20, cycles);
        if (wr_adr.size() != exp_adr.size())
            abort_run($sformatf("%s saw %0d memory writes instead of %0d",
                                name, wr_adr.size(), exp_adr.size()));
        foreach (exp_adr[i]) begin
            check_addr("wb_adr", exp_adr[i], wr_adr[i]);
            check_nib("wb_dat_w", exp_dat[i], wr_dat[i]);
        end
        prog.delete();
        exp_adr.delete();
        exp_dat.delete();
    endtask

    task automatic reset_and_fetch();
        instr_t code [8] = '{12'h123, 12'hA55, 12'hFFF, 12'hD00,
                             12'hE40, 12'hEAC, 12'hE9F, 12'h7E0};
        int     cycles;
        foreach (code[i]) prog.push_back(code[i]);
        start_program();
        for (int i = 1; i <= 8; i++) begin
            wait_for_pc(START_PC + addr_t'(i), 10, cycles);
            if (cycles != 3) abort_run($sformatf("NOP took %0d cycles instead of 3", cycles));
        end
        if (bus_cycles != 0) abort_run("bus activity during unknown opcodes");
        prog.delete();
    endtask

    task automatic x_immediate_loads();
        instr_t code [5] = '{12'hB5A, 12'hE63, 12'hE6C, 12'h97E, 12'hE61};
        addr_t  ea [5] = '{12'h05A, 12'h05B, 12'h05C, 12'h05D, 12'h05E};
        nib_t   ed [5] = '{4'h3, 4'hC, 4'hE, 4'h7, 4'h1};
        foreach (code[i]) prog.push_back(code[i]);
        foreach (ea[i]) expect_write(ea[i], ed[i]);
        run_and_check("X immediate loads");
    endtask

    task automatic y_and_register_loads();
        instr_t code [11] = '{12'h8C3, 12'hE79, 12'hE76, 12'hB20, 12'hE0D, 12'hE14,
                              12'hEC8, 12'hEC9, 12'hECC, 12'hE27, 12'hE32};
        addr_t  ea [7] = '{12'h0C3, 12'h0C4, 12'h020, 12'h020, 12'h0C5, 12'h020, 12'h0C5};
        nib_t   ed [7] = '{4'h9, 4'h6, 4'hD, 4'h4, 4'hD, 4'h7, 4'h2};
        foreach (code[i]) prog.push_back(code[i]);
        foreach (ea[i]) expect_write(ea[i], ed[i]);
        run_and_check("Y and register loads");
    endtask

    // X becomes 0x3A5 and Y 0xC61, then each part is copied back out
    task automatic part_transfers();
        instr_t code [30] = '{12'hE03, 12'hE1A, 12'hE80, 12'hE85, 12'hE05, 12'hE88, 12'hEC9,
                              12'hE0C, 12'hE16, 12'hE90, 12'hE95, 12'hE01, 12'hE98, 12'hECD,
                              12'hEA0, 12'hECC, 12'hEA4, 12'hECC, 12'hEA8, 12'hECC, 12'hEB0,
                              12'hEC8, 12'hEB4, 12'hEC8, 12'hEB8, 12'hEC8, 12'hEA2, 12'hEBB,
                              12'hEA5, 12'hECD};
        addr_t  ea [11] = '{12'h3A5, 12'hC61, 12'hC61, 12'hC61, 12'hC61, 12'h3A5,
                            12'h3A5, 12'h3A5, 12'h3A5, 12'hC61, 12'hC61};
        nib_t   ed [11] = '{4'hA, 4'h6, 4'h3, 4'hA, 4'h5, 4'hC, 4'h6, 4'h1, 4'h3, 4'h1, 4'hA};
        foreach (code[i]) prog.push_back(code[i]);
        foreach (ea[i]) expect_write(ea[i], ed[i]);
        run_and_check("part transfers");
    endtask

    // Kind 0 is LD r,q, 1 is LDPX r,q, 2 is LDPY r,q
    task automatic rq_step(int kind, rcode_t r, rcode_t q);
        nib_t val;
        prog.push_back({4'hE, (kind == 0) ? 4'hC : (kind == 1) ? 4'hE : 4'hF, r, q});
        case (q)
            2'd0:    val = m_a;
            2'd1:    val = m_b;
            2'd2:    val = exp_mem[m_x];
            default: val = exp_mem[m_y];
        endcase
        case (r)
            2'd0:    m_a = val;
            2'd1:    m_b = val;
            2'd2:    expect_write(m_x, val);
            default: expect_write(m_y, val);
        endcase
        if (kind == 1) m_x++;
        if (kind == 2) m_y++;
    endtask

    task automatic memory_source_loads();
        for (int i = 0; i < 4096; i++) exp_mem[i] = ram_fill(addr_t'(i));
        prog.push_back(12'hB40);
        prog.push_back(12'h880);
        prog.push_back(12'hE09);
        prog.push_back(12'hE1E);
        m_x = 12'h040;
        m_y = 12'h080;
        m_a = 4'h9;
        m_b = 4'hE;
        for (int r = 0; r < 4; r++) begin
            for (int q = 0; q < 4; q++) begin
                for (int kind = 0; kind < 3; kind++) begin
                    rq_step(kind, rcode_t'(r), rcode_t'(q));
                    if (r < 2) rq_step(0, 2'd3, rcode_t'(r));   // Store A or B at M(Y)
                end
            end
        end
        run_and_check("memory source transfers");
    endtask

    initial begin
        rst = 1'b1;
        void'($urandom(72));
        reset_and_fetch();
        x_immediate_loads();
        y_and_register_loads();
        part_transfers();
        memory_source_loads();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
e0c_pkg.sv
instr_decode.sv
core_regs.sv
wb_data_port.sv
exec_control.sv
cpu_core.sv
cpu_properties.sv
tb_cpu.sv

//--- run.sh
#!/bin/sh
# Build and run tb_cpu with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_cpu -f tb.f
trap 'cat sim.log' EXIT
./obj_dir/Vtb_cpu > sim.log 2>&1
if grep -q "tests failed" sim.log; then
    exit 1
fi
